//--- filelist.f
logic/cpuIsaPkg.sv
logic/cpuPipePkg.sv
logic/pipeIfs.sv
logic/instrDecoder.sv
logic/aluExec.sv
logic/branchPcUnit.sv
logic/storePort.sv
logic/microCore.sv
tests/instrRom.sv
tests/microCoreTb.sv

//--- Bender.yml
package:
  name: microcore

sources:
  - logic/cpuIsaPkg.sv
  - logic/cpuPipePkg.sv
  - logic/pipeIfs.sv
  - logic/instrDecoder.sv
  - logic/aluExec.sv
  - logic/branchPcUnit.sv
  - logic/storePort.sv
  - logic/microCore.sv
  - target: test
    files:
      - tests/instrRom.sv
      - tests/microCoreTb.sv

//--- tests/microCoreTb.sv
// Testbench for the core, running an LCG built program under random stalls and checking each store
module microCoreTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int AddrWidth = cpuPipePkg::DefaultAddrWidth;
   localparam int PcWidth = AddrWidth - cpuPipePkg::ByteOffsetBits;
   localparam int RomDepth = 256;
   localparam int TimeoutCycles = 5000;

   logic gclk;
   logic grst;
   logic gena;
   logic [PcWidth-1:0] instrAddr;
   cpuPipePkg::instrWordT instr;
   logic [PcWidth-1:0] dataAddr;
   cpuPipePkg::instrWordT dataOut;
   logic dataWe;

   // Program builder state and register model
   logic [31:0] lcgState;
   logic [31:0] model [32];
   int progPc;
   int storeSlot;
   int endPc;
   // Expected writes with the word address in the upper half
   logic [63:0] expQ [$];

   // Stall driver and the outputs seen at the previous negedge
   int stallLeft;
   logic [31:0] draw;
   logic prevGena;
   logic prevRst;
   logic released;
   logic frozenOk;
   logic [2*PcWidth+32:0] prevOutputs;

   microCore #(.AddrWidth(AddrWidth)) uut (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .instrAddr(instrAddr),
      .instr(instr),
      .dataAddr(dataAddr),
      .dataOut(dataOut),
      .dataWe(dataWe)
   );

   instrRom #(.AddrBits(PcWidth), .Depth(RomDepth)) rom (
      .gclk(gclk),
      .gena(gena),
      .addr(instrAddr),
      .data(instr)
   );

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState;
   endfunction

   // Fields rd, ra and a 16-bit low part which holds rb at bit 11 for register forms
   function automatic logic [31:0] encode(cpuIsaPkg::opcodeT op, int rd, int ra, int low);
      return {op, rd[4:0], ra[4:0], low[15:0]};
   endfunction

   // Branch condition as a signed comparison of the ra value with zero
   function automatic bit condHolds(int cond, logic [31:0] v);
      case (cond)
         0: return v == 0;
         1: return v != 0;
         2: return $signed(v) < 0;
         3: return $signed(v) <= 0;
         4: return $signed(v) > 0;
         default: return $signed(v) >= 0;
      endcase
   endfunction

   task automatic emit(input logic [31:0] word);
      rom.mem[progPc] = word;
      progPc++;
   endtask

   // Prefix word with the high half and then add-immediate from r0
   task automatic loadConst(input int rd, input logic [31:0] value);
      emit(encode(cpuIsaPkg::opImm, 0, 0, value[31:16]));
      emit(encode(cpuIsaPkg::opAddI, rd, 0, value[15:0]));
      model[rd] = value;
   endtask

   task automatic aluReg(input cpuIsaPkg::opcodeT op, input int rd, input int ra, input int rb);
      emit(encode(op, rd, ra, rb << 11));
      case (op)
         cpuIsaPkg::opAdd: model[rd] = model[ra] + model[rb];
         cpuIsaPkg::opOr:  model[rd] = model[ra] | model[rb];
         default:          model[rd] = model[ra] & model[rb];
      endcase
   endtask

   task automatic addImm(input int rd, input int ra, input logic [15:0] imm);
      emit(encode(cpuIsaPkg::opAddI, rd, ra, imm));
      model[rd] = model[ra] + {{16{imm[15]}}, imm};
   endtask

   // Every store gets its own word address and only kept ones are expected
   task automatic storeReg(input int rd, input bit kept);
      emit(encode(cpuIsaPkg::opSwi, rd, 0, storeSlot * 4));
      if (kept) expQ.push_back({32'(storeSlot), model[rd]});
      storeSlot++;
   endtask

   task automatic buildProgram();
      int i;
      int cond;
      int target;
      logic [31:0] v;
      bit dly;
      bit take;
      lcgState = 32'd86;
      progPc = 0;
      storeSlot = 16;
      model[0] = '0;
      for (i = 0; i < RomDepth; i++) begin
         rom.mem[i] = {cpuIsaPkg::opOr, 5'd0, 21'(i)};
      end
      // Straight-line ALU work where each result feeds the next word
      for (i = 0; i < 4; i++) begin
         loadConst(1, nextRand());
         loadConst(2, nextRand());
         aluReg(cpuIsaPkg::opAdd, 3, 1, 2);
         aluReg(cpuIsaPkg::opOr, 4, 3, 1);
         storeReg(4, 1);
         aluReg(cpuIsaPkg::opAnd, 5, 4, 2);
         addImm(6, 5, 16'(nextRand() >> 8));
         storeReg(6, 1);
         storeReg(3, 1);
         storeReg(5, 1);
      end
      // Plain branch with two annulled words and one jumped over
      emit(encode(cpuIsaPkg::opBruI, 0, 0, 16));
      storeReg(3, 0);
      storeReg(4, 0);
      storeReg(5, 0);
      storeReg(6, 1);
      // Delayed branch keeps the slot store
      emit(encode(cpuIsaPkg::opBruI, 0, 1 << cpuIsaPkg::DelayBitBru, 16));
      storeReg(3, 1);
      storeReg(4, 0);
      storeReg(5, 0);
      storeReg(6, 1);
      // Return through r7 plus 8 lands four words past the return
      target = progPc + 6;
      loadConst(7, target * 4 - 8);
      emit(encode(cpuIsaPkg::opRtd, 0, 7, 8));
      storeReg(3, 1);
      storeReg(4, 0);
      storeReg(5, 0);
      storeReg(6, 1);
      // Each condition sees a zero, a negative and a positive operand
      for (i = 0; i < 18; i++) begin
         v = nextRand();
         case (i / 6)
            0: v = '0;
            1: v = v | 32'h8000_0000;
            default: v = v & 32'h7fff_ffff;
         endcase
         cond = i % 6;
         dly = nextRand() >> 20;
         take = condHolds(cond, v);
         loadConst(8, v);
         emit(encode(cpuIsaPkg::opBccI, (dly << cpuIsaPkg::DelayBitBcc) + cond, 8, 16));
         storeReg(8, !take || dly);
         storeReg(8, !take);
         storeReg(8, !take);
      end
      // Closing marker store that any stray earlier write would precede
      storeReg(8, 1);
      // Branch to itself
      endPc = progPc;
      emit(encode(cpuIsaPkg::opBruI, 0, 0, 0));
   endtask

   task automatic checkStore();
      logic [63:0] head;
      if (expQ.size() == 0) begin
         reportFailure("A data bus write appeared after all expected stores were seen");
      end else begin
         head = expQ.pop_front();
         assert ({32'(dataAddr), dataOut} === head)
            else reportFailure($sformatf(
               "MISMATCH at %0t: store word %0h data %h, expected %0h data %h",
               $time, dataAddr, dataOut, head[63:32], head[31:0]));
      end
   endtask

   initial begin
      gclk = 1'b0;
      forever #5 gclk = ~gclk;
   end

   // Random stall spans of one to four cycles
   always @(posedge gclk) begin
      if (grst) begin
         gena <= 1'b1;
         stallLeft = 0;
      end else if (stallLeft > 0) begin
         gena <= 1'b0;
         stallLeft--;
      end else begin
         draw = nextRand();
         if (draw[27:25] == 3'd0) begin
            stallLeft = draw[21:20];
            gena <= 1'b0;
         end else begin
            gena <= 1'b1;
         end
      end
   end

   // Reset state on release and frozen outputs after a stalled edge
   always @(negedge gclk) begin
      released = prevRst && !grst;
      frozenOk = prevGena || ({instrAddr, dataAddr, dataOut, dataWe} === prevOutputs);
      prevRst = grst;
      prevGena = gena;
      prevOutputs = {instrAddr, dataAddr, dataOut, dataWe};
      if (released) begin
         assert (instrAddr === '0 && dataWe === 1'b0)
            else reportFailure($sformatf("MISMATCH at %0t: instrAddr %0h dataWe %b after reset",
                                         $time, instrAddr, dataWe));
      end else if (!grst) begin
         assert (frozenOk)
            else reportFailure($sformatf("MISMATCH at %0t: outputs moved while gena was low", $time));
      end
   end

   // A write counts once at the enabled edge that ends it
   always @(negedge gclk) begin
      if (!grst && dataWe === 1'b1 && gena === 1'b1) begin
         checkStore();
      end
   end

   initial begin
      int waited;
      grst = 1'b1;
      gena = 1'b1;
      prevRst = 1'b1;
      prevGena = 1'b1;
      buildProgram();
      repeat (5) @(posedge gclk);
      grst <= 1'b0;
      for (waited = 0; waited < TimeoutCycles; waited++) begin
         @(posedge gclk);
         if (expQ.size() == 0 && instrAddr == endPc) break;
      end
      if (waited >= TimeoutCycles) begin
         reportFailure($sformatf("Timed out with %0d stores still expected", expQ.size()));
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

//--- tests/instrRom.sv
// Synchronous instruction memory model for the core testbench, filled by the testbench before reset
module instrRom #(
   parameter int AddrBits = 14,
   parameter int Depth = 256
) (
   input  logic gclk,
   input  logic gena,
   input  logic [AddrBits-1:0] addr,
   output cpuPipePkg::instrWordT data
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int IndexBits = $clog2(Depth);

   // Program words, written hierarchically by the testbench
   cpuPipePkg::instrWordT mem [Depth];

   // Output word before the first read, an add to r0 that the decoder marks invalid
   initial data = '0;

   // Word comes back one enabled cycle after its address
   // Holds with the core while gena is low
   always @(posedge gclk) begin
      if (gena) begin
         data <= mem[addr[IndexBits-1:0]];
      end
   end

endmodule

//--- logic/microCore.sv
// Top level of the three-stage core, connecting the stages and exposing the bus ports
module microCore #(
   parameter int AddrWidth = cpuPipePkg::DefaultAddrWidth
) (
   input  logic gclk,
   input  logic grst,
   input  logic gena,
   // Instruction bus, word address out and word back one cycle later
   output logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] instrAddr,
   input  cpuPipePkg::instrWordT instr,
   // Data bus, write only
   output logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] dataAddr,
   output cpuPipePkg::instrWordT dataOut,
   output logic dataWe
);

   // Pc of the word now on instr
   logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] fetchPc;

   execIf #(.AddrWidth(AddrWidth)) decBus ();
   resolveIf #(.AddrWidth(AddrWidth)) resBus ();
   storeIf #(.AddrWidth(AddrWidth)) stBus ();

   // Decode
   instrDecoder #(
      .AddrWidth(AddrWidth)
   ) decoder (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .instr(instr),
      .fetchPc(fetchPc),
      .dec(decBus.src),
      .res(resBus.dec)
   );

   // Execute
   aluExec #(
      .AddrWidth(AddrWidth)
   ) exec (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .dec(decBus.alu),
      .res(resBus.alu),
      .st(stBus.src)
   );

   // Fetch sequencing and branch resolution
   branchPcUnit #(
      .AddrWidth(AddrWidth)
   ) bpcu (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .dec(decBus.branch),
      .res(resBus.branch),
      .instrAddr(instrAddr),
      .fetchPc(fetchPc)
   );

   // Data bus output
   storePort #(
      .AddrWidth(AddrWidth)
   ) store (
      .gclk(gclk),
      .grst(grst),
      .gena(gena),
      .st(stBus.sink),
      .dataAddr(dataAddr),
      .dataOut(dataOut),
      .dataWe(dataWe)
   );

endmodule

//--- logic/storePort.sv
// Output stage registering store requests into one-cycle data bus writes
module storePort #(
   parameter int AddrWidth = cpuPipePkg::DefaultAddrWidth
) (
   input  logic gclk,
   input  logic grst,
   input  logic gena,
   storeIf.sink st,
   output logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] dataAddr,
   output cpuPipePkg::instrWordT dataOut,
   output logic dataWe
);

   // Write strobe, low in any cycle without a request
   always_ff @(posedge gclk) begin
      if (grst) begin
         dataWe <= 1'b0;
      end else if (gena) begin
         dataWe <= st.req;
      end
   end

   // Bus payload follows the request
   // Byte offset dropped, the bus is word addressed
   always_ff @(posedge gclk) begin
      if (gena) begin
         dataAddr <= st.addr[AddrWidth-1:cpuPipePkg::ByteOffsetBits];
         dataOut <= st.data;
      end
   end

endmodule

//--- logic/branchPcUnit.sv
// Branch resolution and fetch address sequencing, with delay-slot handling and annul generation
module branchPcUnit #(
   parameter int AddrWidth = cpuPipePkg::DefaultAddrWidth
) (
   input  logic gclk,
   input  logic grst,
   input  logic gena,
   execIf.branch dec,
   resolveIf.branch res,
   output logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] instrAddr,
   output logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] fetchPc
);

   localparam int PcWidth = AddrWidth - cpuPipePkg::ByteOffsetBits;

   logic isBru;
   logic isBcc;
   logic isRtd;
   logic isZero;
   logic isNeg;
   logic condMet;
   logic live;
   logic taken;
   logic delay;
   logic takenQ;
   logic skipQ;
   logic [PcWidth-1:0] pcQ;
   logic [PcWidth-1:0] fetchPcQ;
   logic [PcWidth-1:0] nextPc;

   // Branch class of the executing instruction
   assign isBru = (dec.opcode == cpuIsaPkg::opBru) || (dec.opcode == cpuIsaPkg::opBruI);
   assign isBcc = (dec.opcode == cpuIsaPkg::opBcc) || (dec.opcode == cpuIsaPkg::opBccI);
   assign isRtd = (dec.opcode == cpuIsaPkg::opRtd);

   // Condition test on forwarded ra
   assign isZero = (res.opA == '0);
   assign isNeg = res.opA[31];

   always_comb begin
      case (cpuIsaPkg::condT'(dec.rd[2:0]))
         cpuIsaPkg::condEq: condMet = isZero;
         cpuIsaPkg::condNe: condMet = !isZero;
         cpuIsaPkg::condLt: condMet = isNeg;
         cpuIsaPkg::condLe: condMet = isNeg || isZero;
         cpuIsaPkg::condGt: condMet = !isNeg && !isZero;
         cpuIsaPkg::condGe: condMet = !isNeg;
         // Unused encodings never branch
         default:           condMet = 1'b0;
      endcase
   end

   // An annulled instruction cannot branch
   assign live = dec.valid && !skipQ;
   assign taken = live && (isBru || isRtd || (isBcc && condMet));

   // Return always has a delay slot
   assign delay = (isBru && dec.ra[cpuIsaPkg::DelayBitBru])
                  || (isBcc && dec.rd[cpuIsaPkg::DelayBitBcc])
                  || isRtd;

   // Target from the ALU, word aligned
   assign nextPc = taken ? res.result[AddrWidth-1:cpuPipePkg::ByteOffsetBits]
                         : pcQ + PcWidth'(1);

   always_ff @(posedge gclk) begin
      if (grst) begin
         pcQ <= '0;
         fetchPcQ <= '0;
         takenQ <= 1'b0;
         skipQ <= 1'b0;
      end else if (gena) begin
         pcQ <= nextPc;
         // Pc of the word the memory returns next cycle
         fetchPcQ <= pcQ;
         takenQ <= taken;
         // Without delay both following words die
         // With delay only the second one
         skipQ <= (taken && !delay) || takenQ;
      end
   end

   assign instrAddr = pcQ;
   assign fetchPc = fetchPcQ;
   assign res.skip = skipQ;

   // Pc of the executing instruction as captured by the decoder
   assign res.execPc = dec.pc;

endmodule

//--- logic/aluExec.sv
// Execute stage resolving forwarded operands, computing ALU results and issuing write-back and stores
module aluExec #(
   parameter int AddrWidth = cpuPipePkg::DefaultAddrWidth
) (
   input  logic gclk,
   input  logic grst,
   input  logic gena,
   execIf.alu dec,
   resolveIf.alu res,
   storeIf.src st
);

   cpuPipePkg::instrWordT opA;
   cpuPipePkg::instrWordT opB;
   cpuPipePkg::instrWordT srcB;
   cpuPipePkg::instrWordT pcByte;
   cpuPipePkg::instrWordT result;
   logic live;
   logic isWrite;
   logic isStore;

   // Single forwarding source, the registered result of the previous instruction
   assign opA = dec.fwdA ? res.wbData : dec.regA;
   assign opB = dec.fwdB ? res.wbData : dec.regB;

   // Immediate forms replace the B operand
   assign srcB = dec.opcode[cpuIsaPkg::ImmFormBit] ? dec.imm : opB;

   // Byte address of the executing instruction
   assign pcByte = 32'({res.execPc, {cpuPipePkg::ByteOffsetBits{1'b0}}});

   always_comb begin
      case (dec.opcode)
         cpuIsaPkg::opAdd,
         cpuIsaPkg::opAddI: result = opA + srcB;
         cpuIsaPkg::opOr:   result = opA | srcB;
         cpuIsaPkg::opAnd:  result = opA & srcB;
         // Branch targets are pc relative
         cpuIsaPkg::opBru,
         cpuIsaPkg::opBruI,
         cpuIsaPkg::opBcc,
         cpuIsaPkg::opBccI: result = pcByte + srcB;
         // Return and store address, ra plus immediate
         default:           result = opA + srcB;
      endcase
   end

   // Annulled instructions have no side effects
   assign live = dec.valid && !res.skip;
   assign isWrite = (dec.opcode inside {cpuIsaPkg::opAdd, cpuIsaPkg::opAddI,
                                        cpuIsaPkg::opOr, cpuIsaPkg::opAnd})
                    && (dec.rd != '0);
   assign isStore = (dec.opcode == cpuIsaPkg::opSwi);

   // Strobes
   always_ff @(posedge gclk) begin
      if (grst) begin
         res.wbEn <= 1'b0;
         st.req <= 1'b0;
      end else if (gena) begin
         res.wbEn <= live && isWrite;
         st.req <= live && isStore;
      end
   end

   // Payload, valid only alongside its strobe
   always_ff @(posedge gclk) begin
      if (gena) begin
         res.wbIdx <= dec.rd;
         res.wbData <= result;
         st.addr <= result[AddrWidth-1:0];
         // B port carries rd on a store
         st.data <= opB;
      end
   end

   assign res.opA = opA;
   assign res.result = result;

endmodule

//--- logic/instrDecoder.sv
// Decode stage capturing fetched words, merging the immediate prefix and reading the register file
module instrDecoder #(
   parameter int AddrWidth = cpuPipePkg::DefaultAddrWidth
) (
   input  logic gclk,
   input  logic grst,
   input  logic gena,
   input  cpuPipePkg::instrWordT instr,
   input  logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] fetchPc,
   execIf.src dec,
   resolveIf.dec res
);

   localparam int PcWidth = AddrWidth - cpuPipePkg::ByteOffsetBits;
   localparam int ImmW = cpuIsaPkg::ImmWidth;

   cpuPipePkg::instrWordT instrQ;
   logic [PcWidth-1:0] pcQ;
   logic wordValid;
   logic validQ;
   logic prefixValid;
   logic [ImmW-1:0] prefixHi;
   cpuPipePkg::instrWordT regFile [2**cpuIsaPkg::RegIdxWidth];

   // Control state
   // instr holds a real fetched word from the second enabled cycle after reset
   always_ff @(posedge gclk) begin
      if (grst) begin
         wordValid <= 1'b0;
         validQ <= 1'b0;
         prefixValid <= 1'b0;
      end else if (gena) begin
         wordValid <= 1'b1;
         validQ <= wordValid;
         // Prefix lives for exactly one following instruction
         // An annulled prefix word sets nothing
         prefixValid <= validQ && (dec.opcode == cpuIsaPkg::opImm) && !res.skip;
      end
   end

   // Word, pc and prefix half
   always_ff @(posedge gclk) begin
      if (gena) begin
         instrQ <= instr;
         pcQ <= fetchPc;
         prefixHi <= instrQ[ImmW-1:0];
      end
   end

   // Write-back from execute, index zero never arrives here
   always_ff @(posedge gclk) begin
      if (gena && res.wbEn) begin
         regFile[res.wbIdx] <= res.wbData;
      end
   end

   // Field split
   assign dec.opcode = cpuIsaPkg::opcodeT'(instrQ[31:26]);
   assign dec.rd = instrQ[25:21];
   assign dec.ra = instrQ[20:16];
   // Store reads its data register through the B port
   assign dec.rb = (dec.opcode == cpuIsaPkg::opSwi) ? dec.rd : instrQ[15:11];

   // High half from the prefix, else sign extension
   assign dec.imm = prefixValid ? {prefixHi, instrQ[ImmW-1:0]}
                                : {{(32-ImmW){instrQ[ImmW-1]}}, instrQ[ImmW-1:0]};

   // Register zero reads as zero
   assign dec.regA = (dec.ra == '0) ? '0 : regFile[dec.ra];
   assign dec.regB = (dec.rb == '0) ? '0 : regFile[dec.rb];

   // Last execute result not yet in the file
   assign dec.fwdA = res.wbEn && (res.wbIdx == dec.ra);
   assign dec.fwdB = res.wbEn && (res.wbIdx == dec.rb);

   assign dec.pc = pcQ;
   assign dec.valid = validQ;

endmodule

//--- logic/pipeIfs.sv
// Interfaces linking decode, execute, branch and store blocks inside the core
interface execIf #(
   parameter int AddrWidth = cpuPipePkg::DefaultAddrWidth
);
   cpuIsaPkg::opcodeT opcode;
   logic [cpuIsaPkg::RegIdxWidth-1:0] rd;
   logic [cpuIsaPkg::RegIdxWidth-1:0] ra;
   // B read index, rd for a store
   logic [cpuIsaPkg::RegIdxWidth-1:0] rb;
   // Immediate with any prefix already merged
   cpuPipePkg::instrWordT imm;
   cpuPipePkg::instrWordT regA;
   cpuPipePkg::instrWordT regB;
   logic fwdA;
   logic fwdB;
   logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] pc;
   logic valid;

   modport src (output opcode, rd, ra, rb, imm, regA, regB, fwdA, fwdB, pc, valid);
   modport alu (input opcode, rd, imm, regA, regB, fwdA, fwdB, valid);
   modport branch (input opcode, rd, ra, pc, valid);
endinterface

interface resolveIf #(
   parameter int AddrWidth = cpuPipePkg::DefaultAddrWidth
);
   // Forwarded operand A for the branch test
   cpuPipePkg::instrWordT opA;
   cpuPipePkg::instrWordT result;
   logic wbEn;
   logic [cpuIsaPkg::RegIdxWidth-1:0] wbIdx;
   cpuPipePkg::instrWordT wbData;
   // Annul flag for the instruction now in execute
   logic skip;
   logic [AddrWidth-cpuPipePkg::ByteOffsetBits-1:0] execPc;

   modport alu (output opA, result, wbEn, wbIdx, wbData, input skip, execPc);
   modport branch (input opA, result, output skip, execPc);
   modport dec (input wbEn, wbIdx, wbData, skip);
endinterface

interface storeIf #(
   parameter int AddrWidth = cpuPipePkg::DefaultAddrWidth
);
   logic req;
   // Byte address
   logic [AddrWidth-1:0] addr;
   cpuPipePkg::instrWordT data;

   modport src (output req, addr, data);
   modport sink (input req, addr, data);
endinterface

//--- logic/cpuPipePkg.sv
// Pipeline-level types and address defaults shared by the core stages and the top level
package cpuPipePkg;

   // Byte address width of instruction and data buses unless the top sets another
   localparam int DefaultAddrWidth = 16;

   // Byte offset dropped to form a word address
   localparam int ByteOffsetBits = 2;

   // One 32-bit instruction or data word
   typedef logic [31:0] instrWordT;

endpackage

//--- logic/cpuIsaPkg.sv
// Instruction-set definitions shared by the decoder, execute stage, branch unit and program builder
package cpuIsaPkg;

   // Register index width, 32 general registers
   localparam int RegIdxWidth = 5;

   // Low immediate field, also the width of the prefix half
   localparam int ImmWidth = 16;

   // Opcode bit that selects the immediate operand form
   localparam int ImmFormBit = 3;

   // Delay-slot flag in the ra field of unconditional branches
   localparam int DelayBitBru = 4;

   // Delay-slot flag in the rd field of conditional branches
   localparam int DelayBitBcc = 4;

   // Major opcodes, bits 31:26 of the instruction word
   typedef enum logic [5:0] {
      opAdd  = 6'o00,
      opAddI = 6'o10,
      opOr   = 6'o40,
      opAnd  = 6'o41,
      opBru  = 6'o46,
      opBcc  = 6'o47,
      opImm  = 6'o54,
      opRtd  = 6'o55,
      opBruI = 6'o56,
      opBccI = 6'o57,
      opSwi  = 6'o76
   } opcodeT;

   // Branch conditions, low three bits of rd on a conditional branch
   typedef enum logic [2:0] {
      condEq = 3'd0,
      condNe = 3'd1,
      condLt = 3'd2,
      condLe = 3'd3,
      condGt = 3'd4,
      condGe = 3'd5
   } condT;

endpackage
